/* mips.f */
hw/mipsPkg.sv
hw/aluUnit.sv
hw/regFile.sv
hw/fetchUnit.sv
hw/controlDecoder.sv
hw/hazardUnit.sv
hw/mips.sv
dv/mipsChecker.sv
dv/mipsTb.sv

/* run.sh */
#!/bin/sh
# Builds the mips testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f mips.f --top-module mipsTb -o mipsSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mipsSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

/* dv/mipsTb.sv */
`timescale 1ns/1ps

module mipsTb
	import mipsPkg::*;
();
	localparam int          bodyLen    = 200;
	localparam int          progWords  = bodyLen + 2;
	localparam int          dataWords  = 64;
	localparam int          runTimeout = 6000;
	localparam logic [31:0] loopPc     = resetPc + 32'(4 * bodyLen);

	logic        clk;
	logic        reset;
	logic [31:0] instAddr, instRdata;
	logic [31:0] dataAddr, dataWdata, dataRdata;
	logic        dataWe;
	logic        wbWe;
	logic [4:0]  wbAddr;
	logic [31:0] wbData, wbPc;
	logic [31:0] progMem [progWords];
	logic [31:0] dataInit [dataWords];
	logic [31:0] dataMem [dataWords];
	logic        done;
	int          mismatches, failures;

	mips mips_i (.clk(clk), .reset(reset), .instAddr(instAddr), .instRdata(instRdata),
		.dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe), .dataRdata(dataRdata),
		.wbWe(wbWe), .wbAddr(wbAddr), .wbData(wbData), .wbPc(wbPc));

	mipsChecker #(.progWords(progWords), .dataWords(dataWords)) checker_i (
		.clk(clk), .reset(reset), .progMem(progMem), .dataInit(dataInit),
		.instAddr(instAddr), .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe),
		.wbWe(wbWe), .wbAddr(wbAddr), .wbData(wbData), .wbPc(wbPc),
		.done(done), .mismatches(mismatches), .failures(failures));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Mostly r0..r7 for frequent hazards and now and then r31
	function automatic logic [4:0] randomReg();
		int r;
		r = int'($urandom_range(8));
		return (r == 8) ? 5'd31 : 5'(r);
	endfunction

	function automatic logic [31:0] regInstr(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd);
		return {opSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] immInstr(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		int idx;
		idx = int'((addr - resetPc) >> 2);
		if (addr < resetPc || idx >= progWords) return 32'd0;
		return progMem[idx];
	endfunction

	//////////////////////////////////////////////////
	// Random program with forward control flow only
	//////////////////////////////////////////////////
	task automatic buildProgram();
		logic [5:0]  fnList [5];
		logic [4:0]  rs, rt, rd;
		logic [31:0] jumpAddr;
		logic        prevCtrl;
		int          kind, target;
		fnList = '{fnAddu, fnSubu, fnAnd, fnOr, fnSlt};
		prevCtrl = 1'b0;
		for (int i = 0; i < bodyLen; i++) begin
			rs = randomReg();
			rt = randomReg();
			rd = randomReg();
			// No transfer in a delay slot or right before the final loop
			kind = (prevCtrl || i == bodyLen - 1) ? int'($urandom_range(11))
				: int'($urandom_range(15));
			target = i + 2 + int'($urandom_range(4));
			if (target > bodyLen) target = bodyLen;
			jumpAddr = resetPc + 32'(4 * target);
			case (kind)
				0, 1, 2, 3, 4: progMem[i] = regInstr(fnList[kind], rs, rt, rd);
				5:       progMem[i] = immInstr(opAddiu, rs, rt, 16'($urandom));
				6:       progMem[i] = immInstr(opOri, rs, rt, 16'($urandom));
				7:       progMem[i] = immInstr(opLui, 5'd0, rt, 16'($urandom));
				8, 9:    progMem[i] = immInstr(opLw, 5'd0, rt, 16'(4 * $urandom_range(63)));
				10, 11:  progMem[i] = immInstr(opSw, 5'd0, rt, 16'(4 * $urandom_range(63)));
				12, 13: begin
					if ($urandom_range(1) == 0) rt = rs; // Bias towards taken
					progMem[i] = immInstr(opBeq, rs, rt, 16'(target - i - 1));
				end
				14:      progMem[i] = {opJ, jumpAddr[27:2]};
				default: progMem[i] = {opJal, jumpAddr[27:2]};
			endcase
			prevCtrl = (kind >= 12);
		end
		progMem[bodyLen] = {opJ, loopPc[27:2]};
		progMem[bodyLen + 1] = 32'd0;
	endtask

	// Memories answer 1 ns after the edge; stores land in the same step
	initial begin
		instRdata = 32'd0;
		dataRdata = 32'd0;
		forever begin
			@(posedge clk);
			#1;
			if (dataWe) dataMem[dataAddr[7:2]] = dataWdata;
			instRdata = fetchWord(instAddr);
			dataRdata = dataMem[dataAddr[7:2]];
		end
	end

	initial begin
		int cycles;
		reset = 1'b1;
		void'($urandom(32'h747f_5fa3));
		buildProgram();
		for (int k = 0; k < dataWords; k++) begin
			dataInit[k] = $urandom;
			dataMem[k] = dataInit[k];
		end
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		cycles = 0;
		while (!done && cycles < runTimeout) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) $display("ERROR: checker did not finish within %0d cycles", runTimeout);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (done && mismatches == 0 && failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* dv/mipsChecker.sv */
`timescale 1ns/1ps

module mipsChecker
	import mipsPkg::*;
#(
	parameter int progWords = 202,
	parameter int dataWords = 64
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] progMem [progWords],
	input  logic [31:0] dataInit [dataWords],
	input  logic [31:0] instAddr,
	input  logic [31:0] dataAddr,
	input  logic [31:0] dataWdata,
	input  logic        dataWe,
	input  logic        wbWe,
	input  logic [4:0]  wbAddr,
	input  logic [31:0] wbData,
	input  logic [31:0] wbPc,
	output logic        done,
	output int          mismatches,
	output int          failures
);
	localparam int          resetTimeout = 20;
	localparam int          drainTimeout = 4000;
	localparam int          quietCycles  = 16;
	localparam logic [31:0] loopPc       = resetPc + 32'(4 * (progWords - 2));

	logic [4:0]  expWbAddr [$];
	logic [31:0] expWbData [$];
	logic [31:0] expWbPc [$];
	logic [31:0] expStAddr [$];
	logic [31:0] expStData [$];

	//////////////////////////////////////////////////
	// Instruction-level reference model
	//////////////////////////////////////////////////
	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] mem [dataWords];
		logic [31:0] pc, npc, target, instr, rsVal, rtVal, simm, addr, result;
		logic [4:0]  dest;
		logic        writes;
		int          steps;
		for (int r = 0; r < 32; r++) regs[r] = 32'd0;
		for (int k = 0; k < dataWords; k++) mem[k] = dataInit[k];
		pc = resetPc;
		npc = resetPc + 32'd4;
		steps = 0;
		while (pc != loopPc && steps < progWords) begin
			instr  = progMem[int'((pc - resetPc) >> 2)];
			rsVal  = regs[instr[25:21]];
			rtVal  = regs[instr[20:16]];
			simm   = {{16{instr[15]}}, instr[15:0]};
			addr   = rsVal + simm;
			target = npc + 32'd4; // Sequential after the delay slot
			dest   = instr[20:16];
			writes = 1'b1;
			result = 32'd0;
			case (instr[31:26])
				opSpecial: begin
					dest = instr[15:11];
					case (instr[5:0])
						fnAddu:  result = rsVal + rtVal;
						fnSubu:  result = rsVal - rtVal;
						fnAnd:   result = rsVal & rtVal;
						fnOr:    result = rsVal | rtVal;
						fnSlt:   result = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				opAddiu: result = addr;
				opOri:   result = rsVal | {16'd0, instr[15:0]};
				opLui:   result = {instr[15:0], 16'd0};
				opLw:    result = mem[addr[7:2]];
				opSw: begin
					writes = 1'b0;
					mem[addr[7:2]] = rtVal;
					expStAddr.push_back(addr);
					expStData.push_back(rtVal);
				end
				opBeq: begin
					writes = 1'b0;
					if (rsVal == rtVal) target = npc + (simm << 2);
				end
				opJ: begin
					writes = 1'b0;
					target = {npc[31:28], instr[25:0], 2'b00};
				end
				opJal: begin
					target = {npc[31:28], instr[25:0], 2'b00};
					dest   = 5'd31;
					result = pc + 32'd8; // Return past the delay slot
				end
				default: writes = 1'b0;
			endcase
			if (writes) begin
				expWbAddr.push_back(dest);
				expWbData.push_back(result);
				expWbPc.push_back(pc);
				if (dest != 5'd0) regs[dest] = result;
			end
			pc = npc;
			npc = target;
			steps++;
		end
		if (pc != loopPc) begin
			failures++;
			$display("ERROR: reference model never reached the final loop");
		end
	endtask

	//////////////////////////////////////////////////
	// Trace comparison
	//////////////////////////////////////////////////
	task automatic compareBeats();
		logic [4:0]  a;
		logic [31:0] d, p;
		if (wbWe) begin
			if (expWbAddr.size() == 0) begin
				failures++;
				$display("ERROR at %0t: register write r%0d with none left to expect", $time, wbAddr);
			end else begin
				a = expWbAddr.pop_front();
				d = expWbData.pop_front();
				p = expWbPc.pop_front();
				if (wbAddr !== a || wbData !== d || wbPc !== p) begin
					mismatches++;
					$display("MISMATCH at %0t: write r%0d=%h pc %h, expected r%0d=%h pc %h",
						$time, wbAddr, wbData, wbPc, a, d, p);
				end
			end
		end
		if (dataWe) begin
			if (expStAddr.size() == 0) begin
				failures++;
				$display("ERROR at %0t: store to %h with none left to expect", $time, dataAddr);
			end else begin
				p = expStAddr.pop_front();
				d = expStData.pop_front();
				if (dataAddr !== p || dataWdata !== d) begin
					mismatches++;
					$display("MISMATCH at %0t: store %h to %h, expected %h to %h",
						$time, dataWdata, dataAddr, d, p);
				end
			end
		end
	endtask

	initial begin
		int cycles;
		done = 1'b0;
		mismatches = 0;
		failures = 0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (reset !== 1'b0 && cycles < resetTimeout);
		if (reset !== 1'b0) begin
			failures++;
			$display("ERROR: reset was never released");
		end else begin
			if (instAddr !== resetPc || wbWe !== 1'b0 || dataWe !== 1'b0) begin
				mismatches++;
				$display("MISMATCH at %0t: after reset instAddr %h wbWe %b dataWe %b",
					$time, instAddr, wbWe, dataWe);
			end
			runModel();
			cycles = 0;
			while ((expWbAddr.size() > 0 || expStAddr.size() > 0) && cycles < drainTimeout) begin
				@(negedge clk);
				cycles++;
				compareBeats();
			end
			if (expWbAddr.size() > 0 || expStAddr.size() > 0) begin
				failures++;
				$display("ERROR: timed out with %0d writes and %0d stores still expected",
					expWbAddr.size(), expStAddr.size());
			end
			for (int q = 0; q < quietCycles; q++) begin
				@(negedge clk);
				compareBeats(); // The final loop retires nothing
			end
		end
		done = 1'b1;
	end

endmodule

/* hw/mips.sv */
`timescale 1ns/1ps

module mips
	import mipsPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	output logic [31:0] instAddr,
	input  logic [31:0] instRdata,
	output logic [31:0] dataAddr,
	output logic [31:0] dataWdata,
	output logic        dataWe,
	input  logic [31:0] dataRdata,
	output logic        wbWe,
	output logic [4:0]  wbAddr,
	output logic [31:0] wbData,
	output logic [31:0] wbPc
);
	logic        stall, flush;
	fwdSel       fwdRsDecode, fwdRtDecode, fwdRsExecute, fwdRtExecute;
	logic [31:0] memResult;

	logic [31:0] instrD, pcD, regA, regB, rsValD, rtValD, immD;
	aluOpType    aluOpD;
	npcOpType    npcOpD;
	wbSrc        wbSourceD;
	logic        useImmD, zeroExtD, regWriteD, memWriteD, readsRsD, readsRtD;
	logic [4:0]  destD;

	logic [31:0] pcE, rsValE, rtValE, immE, rsFwdE, rtFwdE, srcBE, aluResultE;
	aluOpType    aluOpE;
	wbSrc        wbSourceE;
	logic        useImmE, regWriteE, memWriteE;
	logic [4:0]  destE, rsE, rtE;

	logic [31:0] pcM, aluResultM, storeDataM;
	wbSrc        wbSourceM;
	logic        regWriteM, memWriteM;
	logic [4:0]  destM;

	logic [31:0] pcW, aluResultW, loadDataW;
	wbSrc        wbSourceW;
	logic        regWriteW;
	logic [4:0]  destW;

	function automatic logic [31:0] fwdMux(input fwdSel sel, input logic [31:0] regVal,
			input logic [31:0] memVal, input logic [31:0] wbVal);
		case (sel)
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return regVal;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Fetch
	//////////////////////////////////////////////////
	fetchUnit uFetch (.clk(clk), .reset(reset), .stall(stall), .npcOp(npcOpD),
		.taken(rsValD == rtValD), .offset(instrD[15:0]), .jumpIndex(instrD[25:0]),
		.pcDecode(pcD), .pc(instAddr));

	always_ff @(posedge clk) begin
		if (reset) begin
			instrD <= 32'd0; // nop
		end else if (!stall) begin
			instrD <= instRdata;
			pcD    <= instAddr;
		end
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	controlDecoder uDecoder (.instr(instrD), .aluOp(aluOpD), .useImm(useImmD),
		.zeroExt(zeroExtD), .regWrite(regWriteD), .memWrite(memWriteD),
		.wbSource(wbSourceD), .npcOp(npcOpD), .destReg(destD),
		.readsRs(readsRsD), .readsRt(readsRtD));

	regFile uRegFile (.clk(clk), .reset(reset), .writeEn(regWriteW), .writeAddr(destW),
		.writeData(wbData), .readAddrA(instrD[25:21]), .readAddrB(instrD[20:16]),
		.readDataA(regA), .readDataB(regB));

	hazardUnit uHazard (.rsDecode(instrD[25:21]), .rtDecode(instrD[20:16]),
		.rsExecute(rsE), .rtExecute(rtE), .readsRsDecode(readsRsD),
		.readsRtDecode(readsRtD), .isBranchDecode(npcOpD == npcBeq),
		.destExecute(destE), .destMemory(destM), .destWriteback(destW),
		.loadExecute(wbSourceE == wbMem), .loadMemory(wbSourceM == wbMem),
		.stall(stall), .flush(flush), .fwdRsDecode(fwdRsDecode),
		.fwdRtDecode(fwdRtDecode), .fwdRsExecute(fwdRsExecute),
		.fwdRtExecute(fwdRtExecute));

	assign rsValD = fwdMux(fwdRsDecode, regA, memResult, wbData); // Also feeds beq
	assign rtValD = fwdMux(fwdRtDecode, regB, memResult, wbData);
	assign immD   = zeroExtD ? {16'd0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			aluOpE    <= aluAdd;
			useImmE   <= 1'b0;
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			wbSourceE <= wbAlu;
			destE     <= 5'd0;
			rsE       <= 5'd0;
			rtE       <= 5'd0;
		end else begin
			aluOpE    <= aluOpD;
			useImmE   <= useImmD;
			regWriteE <= regWriteD;
			memWriteE <= memWriteD;
			wbSourceE <= wbSourceD;
			destE     <= destD;
			rsE       <= readsRsD ? instrD[25:21] : 5'd0;
			rtE       <= readsRtD ? instrD[20:16] : 5'd0;
		end
		pcE    <= pcD;
		rsValE <= rsValD;
		rtValE <= rtValD;
		immE   <= immD;
	end

	//////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////
	assign rsFwdE = fwdMux(fwdRsExecute, rsValE, memResult, wbData);
	assign rtFwdE = fwdMux(fwdRtExecute, rtValE, memResult, wbData);
	assign srcBE  = useImmE ? immE : rtFwdE;

	aluUnit uAlu (.aluOp(aluOpE), .srcA(rsFwdE), .srcB(srcBE), .result(aluResultE));

	always_ff @(posedge clk) begin
		if (reset) begin
			regWriteM <= 1'b0;
			memWriteM <= 1'b0;
			wbSourceM <= wbAlu;
			destM     <= 5'd0;
		end else begin
			regWriteM <= regWriteE;
			memWriteM <= memWriteE;
			wbSourceM <= wbSourceE;
			destM     <= destE;
		end
		pcM        <= pcE;
		aluResultM <= aluResultE;
		storeDataM <= rtFwdE;
	end

	//////////////////////////////////////////////////
	// Memory and writeback
	//////////////////////////////////////////////////
	assign dataAddr  = aluResultM;
	assign dataWdata = storeDataM;
	assign dataWe    = memWriteM;
	assign memResult = (wbSourceM == wbLink) ? pcM + 32'd8 : aluResultM; // jal link

	always_ff @(posedge clk) begin
		if (reset) begin
			regWriteW <= 1'b0;
			wbSourceW <= wbAlu;
			destW     <= 5'd0;
		end else begin
			regWriteW <= regWriteM;
			wbSourceW <= wbSourceM;
			destW     <= destM;
		end
		pcW        <= pcM;
		aluResultW <= aluResultM;
		loadDataW  <= dataRdata;
	end

	always_comb begin
		case (wbSourceW)
			wbMem:   wbData = loadDataW;
			wbLink:  wbData = pcW + 32'd8;
			default: wbData = aluResultW;
		endcase
	end

	assign wbWe   = regWriteW;
	assign wbAddr = destW;
	assign wbPc   = pcW;

	// Fetch and decode both freeze on a stall
	stallHoldsPc: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable(instAddr));

	// A load in memory never has its consumer in execute
	loadUseBubble: assert property (@(posedge clk) disable iff (reset)
		(wbSourceM == wbMem && destM != 5'd0) |-> (rsE != destM && rtE != destM));

endmodule

/* hw/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit
	import mipsPkg::*;
(
	input  logic [4:0] rsDecode,
	input  logic [4:0] rtDecode,
	input  logic [4:0] rsExecute,
	input  logic [4:0] rtExecute,
	input  logic       readsRsDecode,
	input  logic       readsRtDecode,
	input  logic       isBranchDecode,
	input  logic [4:0] destExecute,
	input  logic [4:0] destMemory,
	input  logic [4:0] destWriteback,
	input  logic       loadExecute,
	input  logic       loadMemory,
	output logic       stall,
	output logic       flush,
	output fwdSel      fwdRsDecode,
	output fwdSel      fwdRtDecode,
	output fwdSel      fwdRsExecute,
	output fwdSel      fwdRtExecute
);
	logic [1:0] tuse;
	logic [1:0] tnewExecute;
	logic [1:0] tnewMemory;
	logic       stallRs;
	logic       stallRt;

	// Newest producer wins; load data is not yet valid in memory stage
	function automatic fwdSel pickFwd(input logic [4:0] src, input logic [4:0] memDest,
			input logic [4:0] wbDest, input logic memLoad);
		if (src == 5'd0) return fwdNone;
		if (src == memDest) return memLoad ? fwdNone : fwdMem;
		if (src == wbDest) return fwdWb;
		return fwdNone;
	endfunction

	function automatic logic needsStall(input logic reads, input logic [4:0] src,
			input logic [1:0] tuseSrc, input logic [1:0] tnewE, input logic [1:0] tnewM,
			input logic [4:0] destE, input logic [4:0] destM);
		if (!reads || src == 5'd0) return 1'b0;
		if (src == destE && tnewE >= tuseSrc) return 1'b1; // Execute is a stage further back
		return src == destM && tnewM > tuseSrc;
	endfunction

	assign tuse        = isBranchDecode ? 2'd0 : 2'd1; // Branches compare in decode
	assign tnewExecute = loadExecute ? 2'd1 : 2'd0;
	assign tnewMemory  = loadMemory ? 2'd1 : 2'd0;

	always_comb begin
		stallRs = needsStall(readsRsDecode, rsDecode, tuse, tnewExecute, tnewMemory,
			destExecute, destMemory);
		stallRt = needsStall(readsRtDecode, rtDecode, tuse, tnewExecute, tnewMemory,
			destExecute, destMemory);
		stall = stallRs || stallRt;
		flush = stall; // Bubble into execute
	end

	assign fwdRsDecode  = pickFwd(rsDecode, destMemory, destWriteback, loadMemory);
	assign fwdRtDecode  = pickFwd(rtDecode, destMemory, destWriteback, loadMemory);
	assign fwdRsExecute = pickFwd(rsExecute, destMemory, destWriteback, loadMemory);
	assign fwdRtExecute = pickFwd(rtExecute, destMemory, destWriteback, loadMemory);

endmodule

/* hw/controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder
	import mipsPkg::*;
(
	input  logic [31:0] instr,
	output aluOpType    aluOp,
	output logic        useImm,
	output logic        zeroExt,
	output logic        regWrite,
	output logic        memWrite,
	output wbSrc        wbSource,
	output npcOpType    npcOp,
	output logic [4:0]  destReg,
	output logic        readsRs,
	output logic        readsRt
);
	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] writeTarget;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		// Anything not listed falls through as nop
		aluOp       = aluAdd;
		useImm      = 1'b0;
		zeroExt     = 1'b0;
		regWrite    = 1'b0;
		memWrite    = 1'b0;
		wbSource    = wbAlu;
		npcOp       = npcSeq;
		writeTarget = instr[20:16];
		readsRs     = 1'b0;
		readsRt     = 1'b0;
		case (opcode)
			opSpecial: begin
				writeTarget = instr[15:11]; // rd
				readsRs     = 1'b1;
				readsRt     = 1'b1;
				regWrite    = 1'b1;
				case (funct)
					fnAddu:  aluOp = aluAdd;
					fnSubu:  aluOp = aluSub;
					fnAnd:   aluOp = aluAnd;
					fnOr:    aluOp = aluOr;
					fnSlt:   aluOp = aluSlt;
					default: begin
						regWrite = 1'b0;
						readsRs  = 1'b0;
						readsRt  = 1'b0;
					end
				endcase
			end
			opAddiu: begin
				useImm   = 1'b1;
				regWrite = 1'b1;
				readsRs  = 1'b1;
			end
			opOri: begin
				aluOp    = aluOr;
				useImm   = 1'b1;
				zeroExt  = 1'b1;
				regWrite = 1'b1;
				readsRs  = 1'b1;
			end
			opLui: begin
				aluOp    = aluLui;
				useImm   = 1'b1;
				zeroExt  = 1'b1;
				regWrite = 1'b1;
			end
			opLw: begin
				useImm   = 1'b1;
				regWrite = 1'b1;
				wbSource = wbMem;
				readsRs  = 1'b1;
			end
			opSw: begin
				useImm   = 1'b1;
				memWrite = 1'b1;
				readsRs  = 1'b1;
				readsRt  = 1'b1; // Store data
			end
			opBeq: begin
				npcOp   = npcBeq;
				readsRs = 1'b1;
				readsRt = 1'b1;
			end
			opJ:   npcOp = npcJump;
			opJal: begin
				npcOp       = npcJump;
				regWrite    = 1'b1;
				wbSource    = wbLink;
				writeTarget = 5'd31;
			end
			default: ;
		endcase
	end

	assign destReg = regWrite ? writeTarget : 5'd0;

endmodule

/* hw/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit
	import mipsPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        stall,
	input  npcOpType    npcOp,
	input  logic        taken,
	input  logic [15:0] offset,
	input  logic [25:0] jumpIndex,
	input  logic [31:0] pcDecode,
	output logic [31:0] pc
);
	logic [31:0] pcNext;
	logic [31:0] seqDecode;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;

	// Targets are relative to the delay slot
	assign seqDecode    = pcDecode + 32'd4;
	assign branchTarget = seqDecode + {{14{offset[15]}}, offset, 2'b00};
	assign jumpTarget   = {seqDecode[31:28], jumpIndex, 2'b00};

	always_comb begin
		pcNext = pc + 32'd4;
		if (npcOp == npcBeq && taken) begin
			pcNext = branchTarget;
		end else if (npcOp == npcJump) begin
			pcNext = jumpTarget;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
		end else if (!stall) begin
			pc <= pcNext; // Hold while decode is stalled
		end
	end

	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile
	import mipsPkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        writeEn,
	input  logic [4:0]  writeAddr,
	input  logic [31:0] writeData,
	input  logic [4:0]  readAddrA,
	input  logic [4:0]  readAddrB,
	output logic [31:0] readDataA,
	output logic [31:0] readDataB
);
	logic [31:0] regs [regCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != 5'd0) begin
			regs[writeAddr] <= writeData; // Entry 0 never written
		end
	end

	// Writeback data passes straight to decode in the same cycle
	assign readDataA = (readAddrA == 5'd0) ? 32'd0 :
		(writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == 5'd0) ? 32'd0 :
		(writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

/* hw/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit
	import mipsPkg::*;
(
	input  aluOpType    aluOp,
	input  logic [31:0] srcA,
	input  logic [31:0] srcB,
	output logic [31:0] result
);

	always_comb begin
		case (aluOp)
			aluAdd:  result = srcA + srcB;
			aluSub:  result = srcA - srcB;
			aluAnd:  result = srcA & srcB;
			aluOr:   result = srcA | srcB;
			aluSlt:  result = {31'd0, $signed(srcA) < $signed(srcB)}; // Signed compare
			aluLui:  result = srcB << 16;
			default: result = 32'd0;
		endcase
	end

endmodule

/* hw/mipsPkg.sv */
package mipsPkg;

	//////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ       = 6'h02;
	localparam logic [5:0] opJal     = 6'h03;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2b;

	// Function field of opSpecial
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	//////////////////////////////////////////////////
	// Control codes
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui
	} aluOpType;

	typedef enum logic [1:0] {
		npcSeq, npcBeq, npcJump
	} npcOpType;

	typedef enum logic [1:0] {
		wbAlu, wbMem, wbLink
	} wbSrc;

	typedef enum logic [1:0] {
		fwdNone, fwdMem, fwdWb // Memory stage has priority
	} fwdSel;

	localparam logic [31:0] resetPc  = 32'h0000_3000;
	localparam int          regCount = 32;

endpackage
